//--- verilog/srx_pkg.sv
// ********************
// Shared types and constants for the SRX observation path controller
// Import into any block that touches requests, switches or sample streams
// ********************

`default_nettype none

package srx_pkg;

    // Fixed four antenna board
    localparam int N_ANTENNAS = 4;
    localparam int ANT_IDX_W  = $clog2(N_ANTENNAS);

    // Antenna field width in the request word and tuser
    localparam int ANT_SEL_W = 3;

    // Sample and tag widths on the DPD stream
    localparam int IQ_W    = 32;
    localparam int TUSER_W = 8;

    // Six SPDT switches on the PA board
    localparam int N_SWITCHES = 6;

    // SPDT control levels
    // 1 connects RFC to RF1, 0 connects RFC to RF2
    localparam logic RF_PORT1 = 1'b1;
    localparam logic RF_PORT2 = 1'b0;

    // Active low, so all ones parks every switch
    localparam logic [N_SWITCHES-1:0] SWITCH_OFF_N = 6'h3f;

    // Request types carried in the upper nibble
    typedef enum logic [3:0] {
        REQ_DPD   = 4'h0,
        REQ_HIRES = 4'h1,
        REQ_VSWR  = 4'h2,
        REQ_AVAIL = 4'hf
    } req_type_e;

    // Request word, bit 3 reserved
    typedef struct packed {
        req_type_e              req_type;
        logic                   rsvd;
        logic [ANT_SEL_W-1:0]   ant_sel;
    } srx_req_t;

    // Enables and port selects for the six switches
    typedef struct packed {
        logic [N_SWITCHES-1:0]  en_n;
        logic [N_SWITCHES-1:0]  sel_n;
    } rf_switch_t;

    // Software control levels
    typedef struct packed {
        logic                   override;
        rf_switch_t             rf_switch;
        logic [ANT_SEL_W-1:0]   orx_ant_sel;
        logic [15:0]            ant_switch_delay;
    } hw_ctrl_t;

    // One antenna's IQ stream, Q in [31:16] and I in [15:0]
    typedef struct packed {
        logic [IQ_W-1:0]        tdata;
        logic                   tvalid;
    } sample_stream_t;

    // Stream toward DPD with the granted antenna in tuser
    typedef struct packed {
        logic [IQ_W-1:0]        tdata;
        logic                   tvalid;
        logic [TUSER_W-1:0]     tuser;
    } dpd_stream_t;

endpackage

`default_nettype wire

//--- verilog/srx_req_decode.sv
// ********************
// Request latch and RF switch map
// Holds the accepted request and registers its switch pattern on switch_now
// ********************

`timescale 1ns/1ps
`default_nettype none

module srx_req_decode (
    input  logic                axis_aclk,
    input  logic                rst,
    input  srx_pkg::srx_req_t   req,
    input  logic                accept,
    input  logic                switch_now,
    output logic [2:0]          ant_sel,
    output srx_pkg::rf_switch_t pattern
);

    import srx_pkg::*;

    req_type_e              req_type_q;
    logic [ANT_SEL_W-1:0]   ant_q;
    logic                   req_ok;
    logic                   req_is_dpd;
    rf_switch_t             pattern_next;

    // Request is only presented on the strobe, so hold it here
    always_ff @(posedge axis_aclk) begin
        if (rst) begin
            req_type_q <= REQ_AVAIL;
            ant_q      <= '0;
        end else if (accept) begin
            req_type_q <= req.req_type;
            ant_q      <= req.ant_sel;
        end
    end

    assign ant_sel = ant_q;

    // Only DPD and VSWR requests drive the switches
    assign req_ok     = (req_type_q == REQ_DPD) || (req_type_q == REQ_VSWR);
    assign req_is_dpd = (req_type_q == REQ_DPD);

    always_comb begin
        // Enables, active low
        // First level pairs antennas 0/1 and 2/3
        pattern_next.en_n[0] = ~(req_ok && ((ant_q == 3'd0) || (ant_q == 3'd1)));
        pattern_next.en_n[3] = ~(req_ok && ((ant_q == 3'd2) || (ant_q == 3'd3)));
        // Second level, one switch per antenna
        // Antennas 4 to 7 match none of these and stay off
        pattern_next.en_n[1] = ~(req_ok && (ant_q == 3'd0));
        pattern_next.en_n[2] = ~(req_ok && (ant_q == 3'd1));
        pattern_next.en_n[4] = ~(req_ok && (ant_q == 3'd2));
        pattern_next.en_n[5] = ~(req_ok && (ant_q == 3'd3));

        // Switch 0 picks antenna 0 on RF2, antenna 1 on RF1
        pattern_next.sel_n[0] = (ant_q == 3'd0) ? RF_PORT2 : RF_PORT1;
        // Switch 3 picks antenna 2 on RF2, antenna 3 on RF1
        pattern_next.sel_n[3] = (ant_q == 3'd2) ? RF_PORT2 : RF_PORT1;

        // Per antenna DPD vs VSWR coupler path
        // Even antennas have DPD on RF2, odd ones on RF1
        pattern_next.sel_n[1] = req_is_dpd ? RF_PORT2 : RF_PORT1;
        pattern_next.sel_n[2] = req_is_dpd ? RF_PORT1 : RF_PORT2;
        pattern_next.sel_n[4] = req_is_dpd ? RF_PORT2 : RF_PORT1;
        pattern_next.sel_n[5] = req_is_dpd ? RF_PORT1 : RF_PORT2;
    end

    // Pattern only moves when the sequencer says so
    always_ff @(posedge axis_aclk) begin
        if (rst) begin
            pattern.en_n  <= SWITCH_OFF_N;
            pattern.sel_n <= SWITCH_OFF_N;
        end else if (switch_now) begin
            pattern <= pattern_next;
        end
    end

endmodule

`default_nettype wire

//--- verilog/srx_switch_seq.sv
// ********************
// Accept, switch and settle sequencer
// Takes one request at a time, holds off for the settle count, then grants
// ********************

`timescale 1ns/1ps
`default_nettype none

module srx_switch_seq (
    input  logic        axis_aclk,
    input  logic        rst,
    input  logic        req_valid,
    input  logic [15:0] switch_delay,
    output logic        accept,
    output logic        switch_now,
    output logic        grant
);

    typedef enum logic [1:0] {
        S_IDLE   = 2'd0,
        S_SWITCH = 2'd1,
        S_WAIT   = 2'd2,
        S_GRANT  = 2'd3
    } seq_state_e;

    seq_state_e     state;
    seq_state_e     state_next;
    logic [15:0]    settle_cnt;
    logic           settle_done;

    // Strobes while busy are simply not seen
    assign accept = (state == S_IDLE) && req_valid;

    // Counter value k is seen at edge E(2+k)
    assign settle_done = (settle_cnt == switch_delay);

    always_comb begin
        state_next = state;
        case (state)
            S_IDLE: begin
                if (accept) begin
                    state_next = S_SWITCH;
                end
            end
            // One cycle for the decoder to register the pattern
            S_SWITCH: begin
                state_next = S_WAIT;
            end
            // RF transient settling
            S_WAIT: begin
                if (settle_done) begin
                    state_next = S_GRANT;
                end
            end
            S_GRANT: begin
                state_next = S_IDLE;
            end
            default: begin
                state_next = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge axis_aclk) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Runs only in WAIT, starts from zero each time
    always_ff @(posedge axis_aclk) begin
        if (rst || (state != S_WAIT)) begin
            settle_cnt <= '0;
        end else begin
            settle_cnt <= settle_cnt + 16'd1;
        end
    end

    assign switch_now = (state == S_SWITCH);
    assign grant      = (state == S_GRANT);

endmodule

`default_nettype wire

//--- verilog/srx_path_mux.sv
// ********************
// Output side of the controller
// Override mux and register for the switches, antenna stream select,
// tuser tagging and the WRSSI antenna
// ********************

`timescale 1ns/1ps
`default_nettype none

module srx_path_mux (
    input  logic                    axis_aclk,
    input  logic                    rst,
    input  srx_pkg::hw_ctrl_t       ctrl,
    input  srx_pkg::rf_switch_t     pattern,
    input  logic [2:0]              ant_sel,
    input  logic                    grant,
    input  srx_pkg::sample_stream_t srx_in [srx_pkg::N_ANTENNAS],
    output srx_pkg::dpd_stream_t    dpd_out,
    output srx_pkg::rf_switch_t     rf_switch,
    output logic [2:0]              wrssi_ant
);

    import srx_pkg::*;

    logic [ANT_SEL_W-1:0]   granted_ant;
    sample_stream_t         sel_stream;

    // Software override wins over the decoded pattern
    // Registered after the mux so the pins see it one edge later
    always_ff @(posedge axis_aclk) begin
        if (rst) begin
            rf_switch.en_n  <= SWITCH_OFF_N;
            rf_switch.sel_n <= SWITCH_OFF_N;
        end else if (ctrl.override) begin
            rf_switch <= ctrl.rf_switch;
        end else begin
            rf_switch <= pattern;
        end
    end

    // Antenna handed to DPD, changes only on grant
    always_ff @(posedge axis_aclk) begin
        if (rst) begin
            granted_ant <= '0;
        end else if (grant) begin
            granted_ant <= ant_sel;
        end
    end

    // Out of range antennas fall back to antenna 0
    always_comb begin
        if (granted_ant < ANT_SEL_W'(N_ANTENNAS)) begin
            sel_stream = srx_in[granted_ant[ANT_IDX_W-1:0]];
        end else begin
            sel_stream = srx_in[0];
        end
    end

    // Samples pass straight through, tuser tells DPD the switch is done
    always_comb begin
        dpd_out.tdata                  = sel_stream.tdata;
        dpd_out.tvalid                 = sel_stream.tvalid;
        dpd_out.tuser                  = '0;
        dpd_out.tuser[ANT_SEL_W-1:0]   = granted_ant;
    end

    // WRSSI follows whatever antenna is actually on the switches
    always_ff @(posedge axis_aclk) begin
        if (rst) begin
            wrssi_ant <= '0;
        end else if (ctrl.override) begin
            wrssi_ant <= ctrl.orx_ant_sel;
        end else begin
            wrssi_ant <= ant_sel;
        end
    end

endmodule

`default_nettype wire

//--- verilog/srx_ctrl_top.sv
// ********************
// Top level of the SRX observation path controller
// Decode, sequence and output blocks wired together
// Sample tready is fanned out from DPD to every antenna
// ********************

`timescale 1ns/1ps
`default_nettype none

module srx_ctrl_top (
    input  logic                            axis_aclk,
    input  logic                            rst,
    // Request strobe from DPD or VSWR
    input  logic                            req_valid,
    input  srx_pkg::srx_req_t               req,
    // Software control
    input  srx_pkg::hw_ctrl_t               ctrl,
    // Per antenna sample streams
    input  srx_pkg::sample_stream_t         srx_in [srx_pkg::N_ANTENNAS],
    output logic [srx_pkg::N_ANTENNAS-1:0]  srx_tready,
    // Stream toward DPD
    output srx_pkg::dpd_stream_t            dpd_out,
    input  logic                            dpd_tready,
    // RF switch pins and WRSSI antenna
    output srx_pkg::rf_switch_t             rf_switch,
    output logic [2:0]                      wrssi_ant
);

    import srx_pkg::*;

    logic           accept;
    logic           switch_now;
    logic           grant;
    logic [2:0]     ant_sel;
    rf_switch_t     pattern;

    // No back-pressure handling here, DPD ready goes to every antenna
    assign srx_tready = {N_ANTENNAS{dpd_tready}};

    srx_req_decode u_decode (
        .axis_aclk  (axis_aclk),
        .rst        (rst),
        .req        (req),
        .accept     (accept),
        .switch_now (switch_now),
        .ant_sel    (ant_sel),
        .pattern    (pattern)
    );

    // Settle count comes straight from software
    srx_switch_seq u_seq (
        .axis_aclk    (axis_aclk),
        .rst          (rst),
        .req_valid    (req_valid),
        .switch_delay (ctrl.ant_switch_delay),
        .accept       (accept),
        .switch_now   (switch_now),
        .grant        (grant)
    );

    srx_path_mux u_mux (
        .axis_aclk (axis_aclk),
        .rst       (rst),
        .ctrl      (ctrl),
        .pattern   (pattern),
        .ant_sel   (ant_sel),
        .grant     (grant),
        .srx_in    (srx_in),
        .dpd_out   (dpd_out),
        .rf_switch (rf_switch),
        .wrssi_ant (wrssi_ant)
    );

endmodule

`default_nettype wire

//--- dv/tb_srx_ctrl.sv
// ********************
// Self-checking testbench for the SRX observation path controller
// Drives requests, control and antenna streams into srx_ctrl_top and
// checks switch patterns, tuser timing, stream selection and override
// ********************

`timescale 1ns/1ps
`default_nettype none

module tb_srx_ctrl;

    import srx_pkg::*;

    // Longest settle count used by any request
    localparam int MAX_DELAY = 15;
    // Requests per test: switching 8, invalid 16, stream 4, busy drop 1
    localparam int N_REQUESTS = 8 + 16 + 4 + 1;
    // Hold cycles in stream, override and busy drop tests
    localparam int DWELL_CYCLES = 4 * 16 + 8 + 8;
    localparam int TIMEOUT_CYCLES = N_REQUESTS * (MAX_DELAY + 4) + DWELL_CYCLES + 10 + 100;

    logic           axis_aclk = 1'b0;
    logic           rst;
    logic           req_valid;
    srx_req_t       req;
    hw_ctrl_t       ctrl;
    sample_stream_t srx_in [N_ANTENNAS];
    logic [N_ANTENNAS-1:0] srx_tready;
    dpd_stream_t    dpd_out;
    logic           dpd_tready;
    rf_switch_t     rf_switch;
    logic [2:0]     wrssi_ant;

    logic [31:0]    rng = 32'hc7e5d2ca;
    int             err_count = 0;
    int             errs_at_start = 0;
    int             tests_run = 0;
    int             tests_failed = 0;
    int             cycle_cnt = 0;
    // Model state
    logic [2:0]     exp_ant = 3'd0;
    logic [2:0]     last_ant = 3'd0;
    rf_switch_t     last_pattern = '{en_n: SWITCH_OFF_N, sel_n: SWITCH_OFF_N};
    logic           stream_check_en = 1'b0;
    logic [1:0]     stream_idx;

    always #5 axis_aclk = ~axis_aclk;

    srx_ctrl_top uut (
        .axis_aclk  (axis_aclk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .ctrl       (ctrl),
        .srx_in     (srx_in),
        .srx_tready (srx_tready),
        .dpd_out    (dpd_out),
        .dpd_tready (dpd_tready),
        .rf_switch  (rf_switch),
        .wrssi_ant  (wrssi_ant)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] rand32();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // Expected switch map, straight from the antenna and type rules
    function automatic rf_switch_t ref_pattern(input req_type_e t, input logic [2:0] ant);
        rf_switch_t p;
        p.en_n = SWITCH_OFF_N;
        if ((t == REQ_DPD) || (t == REQ_VSWR)) begin
            // Pair switch plus the antenna's own switch, active low
            case (ant)
                3'd0:    p.en_n = 6'b111100;
                3'd1:    p.en_n = 6'b111010;
                3'd2:    p.en_n = 6'b100111;
                3'd3:    p.en_n = 6'b010111;
                default: begin end
            endcase
        end
        p.sel_n[0] = (ant == 3'd0) ? RF_PORT2 : RF_PORT1;
        p.sel_n[3] = (ant == 3'd2) ? RF_PORT2 : RF_PORT1;
        if (t == REQ_DPD) begin
            {p.sel_n[5], p.sel_n[4], p.sel_n[2], p.sel_n[1]} =
                {RF_PORT1, RF_PORT2, RF_PORT1, RF_PORT2};
        end else begin
            {p.sel_n[5], p.sel_n[4], p.sel_n[2], p.sel_n[1]} =
                {RF_PORT2, RF_PORT1, RF_PORT2, RF_PORT1};
        end
        return p;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("ERROR time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
        err_count++;
    endtask

    // One falling edge, then fresh samples on every antenna
    task automatic next_cycle();
        logic [31:0] r;
        @(negedge axis_aclk);
        for (int i = 0; i < N_ANTENNAS; i++) begin
            r = rand32();
            srx_in[i].tdata  = r;
            srx_in[i].tvalid = r[7] ^ r[20];
        end
        r = rand32();
        dpd_tready = r[3];
    endtask

    // Issues a request at E0 and checks each edge up to E(3+delay)
    task automatic run_request(input req_type_e t, input logic [2:0] ant, input int delay,
                               input logic busy_strobe);
        rf_switch_t exp_pat;
        rf_switch_t old_pat;
        logic [2:0] old_ant;
        exp_pat = ref_pattern(t, ant);
        old_pat = last_pattern;
        old_ant = exp_ant;
        ctrl.ant_switch_delay = 16'(delay);
        req       = '{req_type: t, rsvd: 1'b0, ant_sel: ant};
        req_valid = 1'b1;
        next_cycle();
        req_valid = 1'b0;
        for (int k = 1; k <= delay + 3; k++) begin
            next_cycle();
            // Output register lags the decoded pattern by one edge
            if (k >= 2) begin
                if (rf_switch !== exp_pat)
                    report_mismatch("rf_switch", 32'(exp_pat), 32'(rf_switch));
            end else begin
                if (rf_switch !== old_pat)
                    report_mismatch("rf_switch", 32'(old_pat), 32'(rf_switch));
            end
            if (k < delay + 3) begin
                if (dpd_out.tuser !== {5'd0, old_ant})
                    report_mismatch("dpd_out.tuser", {29'd0, old_ant}, 32'(dpd_out.tuser));
            end else begin
                if (dpd_out.tuser !== {5'd0, ant})
                    report_mismatch("dpd_out.tuser", {29'd0, ant}, 32'(dpd_out.tuser));
            end
            if (wrssi_ant !== ant)
                report_mismatch("wrssi_ant", {29'd0, ant}, {29'd0, wrssi_ant});
            // Second strobe lands at E2, while the sequencer sits in WAIT
            if (busy_strobe && (k == 1)) begin
                req       = '{req_type: REQ_DPD, rsvd: 1'b0, ant_sel: 3'(ant + 3'd2)};
                req_valid = 1'b1;
            end
            if (k == 2) begin
                req_valid = 1'b0;
            end
        end
        exp_ant      = ant;
        last_ant     = ant;
        last_pattern = exp_pat;
    endtask

    // Idle cycles with everything expected to hold
    task automatic hold_check(input int n);
        for (int i = 0; i < n; i++) begin
            next_cycle();
            if (rf_switch !== last_pattern)
                report_mismatch("rf_switch", 32'(last_pattern), 32'(rf_switch));
            if (dpd_out.tuser !== {5'd0, exp_ant})
                report_mismatch("dpd_out.tuser", {29'd0, exp_ant}, 32'(dpd_out.tuser));
            if (wrssi_ant !== last_ant)
                report_mismatch("wrssi_ant", {29'd0, last_ant}, {29'd0, wrssi_ant});
        end
    endtask

    function automatic int rand_delay();
        logic [31:0] r;
        r = rand32();
        return int'(r[3:0]);
    endfunction

    task automatic start_test();
        errs_at_start = err_count;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (err_count == errs_at_start) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", tests_run, name,
                     err_count - errs_at_start);
        end
    endtask

    // Stream compare, 2 ns after the falling edge drive
    always @(negedge axis_aclk) begin
        #2;
        if (stream_check_en) begin
            // Antennas 4 to 7 fall back to antenna 0
            stream_idx = exp_ant[2] ? 2'd0 : exp_ant[1:0];
            if (dpd_out.tdata !== srx_in[stream_idx].tdata)
                report_mismatch("dpd_out.tdata", srx_in[stream_idx].tdata, dpd_out.tdata);
            if (dpd_out.tvalid !== srx_in[stream_idx].tvalid)
                report_mismatch("dpd_out.tvalid", {31'd0, srx_in[stream_idx].tvalid},
                                {31'd0, dpd_out.tvalid});
            if (srx_tready !== {N_ANTENNAS{dpd_tready}})
                report_mismatch("srx_tready", {28'd0, {N_ANTENNAS{dpd_tready}}},
                                {28'd0, srx_tready});
        end
    end

    // Watchdog sized from the request count and the longest settle
    always @(posedge axis_aclk) begin
        cycle_cnt++;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        rf_switch_t ovr;
        logic [31:0] r;
        rst        = 1'b1;
        req_valid  = 1'b0;
        req        = '{req_type: REQ_AVAIL, rsvd: 1'b0, ant_sel: 3'd0};
        ctrl       = '0;
        dpd_tready = 1'b0;
        for (int i = 0; i < N_ANTENNAS; i++) begin
            srx_in[i] = '0;
        end
        repeat (10) next_cycle();
        rst = 1'b0;
        stream_check_en = 1'b1;

        start_test();
        if (rf_switch !== last_pattern)
            report_mismatch("rf_switch", 32'(last_pattern), 32'(rf_switch));
        if (dpd_out.tuser !== 8'd0)
            report_mismatch("dpd_out.tuser", 32'd0, 32'(dpd_out.tuser));
        if (wrssi_ant !== 3'd0)
            report_mismatch("wrssi_ant", 32'd0, {29'd0, wrssi_ant});
        finish_test("reset state");

        start_test();
        for (int a = 0; a < N_ANTENNAS; a++) begin
            run_request(REQ_DPD, 3'(a), rand_delay(), 1'b0);
            run_request(REQ_VSWR, 3'(a), rand_delay(), 1'b0);
        end
        finish_test("dpd and vswr switching");

        // Bad types on good antennas, then good types on bad antennas
        start_test();
        for (int a = 0; a < N_ANTENNAS; a++) begin
            run_request(REQ_HIRES, 3'(a), rand_delay(), 1'b0);
            run_request(REQ_AVAIL, 3'(a), rand_delay(), 1'b0);
        end
        for (int a = 4; a < 8; a++) begin
            run_request(REQ_DPD, 3'(a), rand_delay(), 1'b0);
            run_request(REQ_VSWR, 3'(a), rand_delay(), 1'b0);
        end
        finish_test("invalid requests");

        start_test();
        for (int a = 0; a < N_ANTENNAS; a++) begin
            run_request(REQ_DPD, 3'(a), rand_delay(), 1'b0);
            hold_check(16);
        end
        finish_test("stream selection");

        start_test();
        ctrl.override = 1'b1;
        for (int i = 0; i < 7; i++) begin
            r = rand32();
            ovr = rf_switch_t'(r[11:0]);
            ctrl.rf_switch   = ovr;
            ctrl.orx_ant_sel = r[18:16];
            next_cycle();
            if (rf_switch !== ovr)
                report_mismatch("rf_switch", 32'(ovr), 32'(rf_switch));
            if (wrssi_ant !== r[18:16])
                report_mismatch("wrssi_ant", {29'd0, r[18:16]}, {29'd0, wrssi_ant});
        end
        // Decoded values come back one edge after release
        ctrl.override = 1'b0;
        hold_check(1);
        finish_test("override");

        start_test();
        run_request(REQ_VSWR, 3'd1, rand_delay(), 1'b1);
        hold_check(8);
        finish_test("busy drop");

        $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
                 err_count);
        if (err_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
verilog/srx_pkg.sv
verilog/srx_req_decode.sv
verilog/srx_switch_seq.sv
verilog/srx_path_mux.sv
verilog/srx_ctrl_top.sv
dv/tb_srx_ctrl.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the SRX controller testbench with Verilator, run it, check the log

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --timescale 1ns/1ps \
    -f all.f \
    --top-module tb_srx_ctrl \
    -Mdir "$BUILD_DIR" \
    -o sim_tb_srx_ctrl
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_tb_srx_ctrl" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG_FILE"; then
    exit 0
else
    echo "Pass message not found in $LOG_FILE"
    exit 1
fi
